// ==== rtl/adc_defs.svh ====
// ----------------------------------------
// capture back end shared sizes
// sample width, lane counts, sync depths
// ----------------------------------------
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// 10-bit converter samples, 4 per lane word
`define SAMPLE_W         10
`define NUM_LANES        4
`define SAMPLES_PER_LANE 4
`define RST_SYNC_STAGES  2
`define SYNC_STAGES      2

`endif

// ==== rtl/adc_data_pkg.sv ====
// ----------------------------------------
// data types for the converter paths
// samples, lane words, overrange flags
// ----------------------------------------
`include "adc_defs.svh"

package adc_data_pkg;

    // one converter sample
    typedef logic [`SAMPLE_W-1:0] sample_t;

    // lane word, sample 0 in the low bits
    typedef logic [`SAMPLES_PER_LANE*`SAMPLE_W-1:0] lane_word_t;

    // one overrange flag per lane
    typedef logic [`NUM_LANES-1:0] lane_or_t;

    // reordered block, index = group*4 + position
    typedef logic [`NUM_LANES*`SAMPLES_PER_LANE*`SAMPLE_W-1:0] sample_block_t;

endpackage

// ==== rtl/adc_ctrl_pkg.sv ====
// ----------------------------------------
// control types for the capture back end
// ----------------------------------------
package adc_ctrl_pkg;

    // converter interleave mode, unknown codes act as 4-channel
    typedef enum logic [3:0] {
        MODE_4CH = 4'b0000,
        MODE_2CH = 4'b0100,
        MODE_1CH = 4'b1000
    } interleave_mode_t;

    // readiness tracking
    typedef enum logic {WAIT_READY = 1'b0, RUN = 1'b1} capture_state_t;

endpackage

// ==== rtl/adc_frame_if.sv ====
// ----------------------------------------
// captured frame of one converter
// lane capture -> sample reordering
// ----------------------------------------
`timescale 1ns/1ps

interface adc_frame_if;
    import adc_data_pkg::*;

    // four lane words plus overrange flags
    lane_word_t lane_a;
    lane_word_t lane_b;
    lane_word_t lane_c;
    lane_word_t lane_d;
    lane_or_t   lane_or;
    // qualifies the lanes for one cycle, no back-pressure
    logic       valid;

    modport producer (output lane_a, lane_b, lane_c, lane_d, lane_or, valid);
    modport consumer (input lane_a, lane_b, lane_c, lane_d, lane_or, valid);

endinterface

// ==== rtl/capture_sync.sv ====
// ----------------------------------------
// capture control
// internal reset from board reset and lock,
// converter readiness FSM and sync trigger
// ----------------------------------------
`timescale 1ns/1ps
`include "adc_defs.svh"

module capture_sync (
    input  logic clk10m,
    input  logic sysrst_nr0,
    input  logic clk10m_locked,
    input  logic a_adc_ready,
    input  logic b_adc_ready,
    input  logic sync_flag,
    output logic rst_sync_n,
    output logic capture_en,
    output logic trig_ext
);
    import adc_ctrl_pkg::*;

    logic                        board_rst_n;
    logic [`RST_SYNC_STAGES-1:0] rst_sh;
    logic [`SYNC_STAGES-1:0]     sync_sh;
    logic                        sync_dly;
    capture_state_t              state;
    capture_state_t              state_nxt;

    // ----------------------------------------
    // reset: held while board reset or unlocked
    // ----------------------------------------
    assign board_rst_n = sysrst_nr0 & clk10m_locked;

    // async assert, release after the stages fill
    always_ff @(posedge clk10m or negedge board_rst_n) begin
        if (!board_rst_n) begin
            rst_sh <= '0;
        end else begin
            rst_sh <= {rst_sh[`RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_sync_n = rst_sh[`RST_SYNC_STAGES-1];

    // ----------------------------------------
    // readiness of both converters
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_READY: if (a_adc_ready && b_adc_ready) state_nxt = RUN;
            RUN:        if (!(a_adc_ready && b_adc_ready)) state_nxt = WAIT_READY;
            default:    state_nxt = WAIT_READY;
        endcase
    end

    always_ff @(posedge clk10m or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            state <= WAIT_READY;
        end else begin
            state <= state_nxt;
        end
    end

    // frames pass only in RUN
    assign capture_en = (state == RUN);

    // ----------------------------------------
    // sync flag: two stages, delay, edge pulse
    // ----------------------------------------
    always_ff @(posedge clk10m or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            sync_sh  <= '0;
            sync_dly <= 1'b0;
            trig_ext <= 1'b0;
        end else begin
            sync_sh  <= {sync_sh[`SYNC_STAGES-2:0], sync_flag};
            sync_dly <= sync_sh[`SYNC_STAGES-1];
            // one cycle on the rising edge only
            trig_ext <= sync_sh[`SYNC_STAGES-1] & ~sync_dly;
        end
    end

endmodule

// ==== rtl/lane_capture.sv ====
// ----------------------------------------
// lane capture
// registers one converter's lane words and
// overrange flags on an accepted frame
// ----------------------------------------
`timescale 1ns/1ps

module lane_capture (
    input  logic                     clk10m,
    input  logic                     rst_sync_n,
    input  logic                     capture_en,
    input  adc_data_pkg::lane_word_t lane_a,
    input  adc_data_pkg::lane_word_t lane_b,
    input  adc_data_pkg::lane_word_t lane_c,
    input  adc_data_pkg::lane_word_t lane_d,
    input  adc_data_pkg::lane_or_t   lane_or,
    input  logic                     frame_valid,
    adc_frame_if.producer            frame
);

    logic accept;

    // frame taken only when both converters already ready
    assign accept = frame_valid & capture_en;

    // valid lasts one cycle per accepted frame
    always_ff @(posedge clk10m or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            frame.valid <= 1'b0;
        end else begin
            frame.valid <= accept;
        end
    end

    // payload holds between frames
    always_ff @(posedge clk10m) begin
        if (accept) begin
            frame.lane_a  <= lane_a;
            frame.lane_b  <= lane_b;
            frame.lane_c  <= lane_c;
            frame.lane_d  <= lane_d;
            frame.lane_or <= lane_or;
        end
    end

endmodule

// ==== rtl/sample_reorder.sv ====
// ----------------------------------------
// sample reordering
// maps a frame's 16 samples into output
// order by the converter interleave mode
// ----------------------------------------
`timescale 1ns/1ps
`include "adc_defs.svh"

module sample_reorder (
    input  logic                          clk10m,
    input  logic                          rst_sync_n,
    input  adc_ctrl_pkg::interleave_mode_t mode,
    adc_frame_if.consumer                 frame,
    output adc_data_pkg::sample_block_t   samples,
    output adc_data_pkg::lane_or_t        data_or,
    output logic                          samples_valid
);
    import adc_ctrl_pkg::*;
    import adc_data_pkg::*;

    lane_word_t    lanes [`NUM_LANES];
    sample_block_t block_nxt;

    // lane index 0..3 = A, B, C, D
    assign lanes[0] = frame.lane_a;
    assign lanes[1] = frame.lane_b;
    assign lanes[2] = frame.lane_c;
    assign lanes[3] = frame.lane_d;

    // ----------------------------------------
    // source lane and sample per output slot
    // ----------------------------------------
    always_comb begin : map_samples
        logic [1:0] li;
        logic [1:0] si;
        block_nxt = '0;
        for (int g = 0; g < `NUM_LANES; g++) begin
            for (int p = 0; p < `SAMPLES_PER_LANE; p++) begin
                case (mode)
                    // A_g C_g B_g D_g, lane index is p with bits swapped
                    MODE_1CH: begin
                        li = {p[0], p[1]};
                        si = g[1:0];
                    end
                    // groups 0/1 pair A,B; groups 2/3 pair C,D
                    MODE_2CH: begin
                        li = {g[1], p[0]};
                        si = {g[0], p[1]};
                    end
                    // four-channel and unknown codes: straight copy
                    default: begin
                        li = g[1:0];
                        si = p[1:0];
                    end
                endcase
                block_nxt[(g*`SAMPLES_PER_LANE+p)*`SAMPLE_W +: `SAMPLE_W] =
                    lanes[li][si*`SAMPLE_W +: `SAMPLE_W];
            end
        end
    end

    // output valid follows the frame by one edge
    always_ff @(posedge clk10m or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            samples_valid <= 1'b0;
        end else begin
            samples_valid <= frame.valid;
        end
    end

    always_ff @(posedge clk10m) begin
        if (frame.valid) begin
            samples <= block_nxt;
            data_or <= frame.lane_or;
        end
    end

endmodule

// ==== rtl/adc_capture_top.sv ====
// ----------------------------------------
// dual converter capture back end
// two lane capture and reorder paths
// sharing one control block
// ----------------------------------------
`timescale 1ns/1ps

module adc_capture_top (
    input  logic                           clk10m,
    input  logic                           sysrst_nr0,
    input  logic                           clk10m_locked,
    // converter a
    input  adc_data_pkg::lane_word_t       a_lane_a,
    input  adc_data_pkg::lane_word_t       a_lane_b,
    input  adc_data_pkg::lane_word_t       a_lane_c,
    input  adc_data_pkg::lane_word_t       a_lane_d,
    input  adc_data_pkg::lane_or_t         a_lane_or,
    input  logic                           a_frame_valid,
    input  adc_ctrl_pkg::interleave_mode_t a_mode,
    // converter b
    input  adc_data_pkg::lane_word_t       b_lane_a,
    input  adc_data_pkg::lane_word_t       b_lane_b,
    input  adc_data_pkg::lane_word_t       b_lane_c,
    input  adc_data_pkg::lane_word_t       b_lane_d,
    input  adc_data_pkg::lane_or_t         b_lane_or,
    input  logic                           b_frame_valid,
    input  adc_ctrl_pkg::interleave_mode_t b_mode,
    // control
    input  logic                           a_adc_ready,
    input  logic                           b_adc_ready,
    input  logic                           sync_flag,
    // outputs
    output adc_data_pkg::sample_block_t    a_samples,
    output adc_data_pkg::sample_block_t    b_samples,
    output logic                           a_samples_valid,
    output logic                           b_samples_valid,
    output adc_data_pkg::lane_or_t         a_data_or,
    output adc_data_pkg::lane_or_t         b_data_or,
    output logic                           capture_ready,
    output logic                           trig_ext
);

    logic rst_sync_n;

    adc_frame_if a_frame ();
    adc_frame_if b_frame ();

    // ----------------------------------------
    // shared reset, readiness and trigger
    // ----------------------------------------
    capture_sync u_capture_sync (
        .clk10m        (clk10m),
        .sysrst_nr0    (sysrst_nr0),
        .clk10m_locked (clk10m_locked),
        .a_adc_ready   (a_adc_ready),
        .b_adc_ready   (b_adc_ready),
        .sync_flag     (sync_flag),
        .rst_sync_n    (rst_sync_n),
        .capture_en    (capture_ready),
        .trig_ext      (trig_ext)
    );

    // converter a path
    lane_capture u_a_capture (
        .clk10m      (clk10m),
        .rst_sync_n  (rst_sync_n),
        .capture_en  (capture_ready),
        .lane_a      (a_lane_a),
        .lane_b      (a_lane_b),
        .lane_c      (a_lane_c),
        .lane_d      (a_lane_d),
        .lane_or     (a_lane_or),
        .frame_valid (a_frame_valid),
        .frame       (a_frame.producer)
    );

    sample_reorder u_a_reorder (
        .clk10m        (clk10m),
        .rst_sync_n    (rst_sync_n),
        .mode          (a_mode),
        .frame         (a_frame.consumer),
        .samples       (a_samples),
        .data_or       (a_data_or),
        .samples_valid (a_samples_valid)
    );

    // converter b path
    lane_capture u_b_capture (
        .clk10m      (clk10m),
        .rst_sync_n  (rst_sync_n),
        .capture_en  (capture_ready),
        .lane_a      (b_lane_a),
        .lane_b      (b_lane_b),
        .lane_c      (b_lane_c),
        .lane_d      (b_lane_d),
        .lane_or     (b_lane_or),
        .frame_valid (b_frame_valid),
        .frame       (b_frame.producer)
    );

    sample_reorder u_b_reorder (
        .clk10m        (clk10m),
        .rst_sync_n    (rst_sync_n),
        .mode          (b_mode),
        .frame         (b_frame.consumer),
        .samples       (b_samples),
        .data_or       (b_data_or),
        .samples_valid (b_samples_valid)
    );

endmodule

// ==== tb/clk_gen.sv ====
// ----------------------------------------
// testbench clock
// free running 10 MHz clk10m
// ----------------------------------------
`timescale 1ns/1ps

module clk_gen (
    output logic clk10m
);

    // 100 ns period
    initial begin
        clk10m = 1'b0;
        forever #50 clk10m = ~clk10m;
    end

endmodule

// ==== tb/adc_capture_assertions.sv ====
// ----------------------------------------
// capture back end checks
// concurrent properties bound into the top
// level, outputs against sampled inputs
// ----------------------------------------
`timescale 1ns/1ps
`include "adc_defs.svh"

module adc_capture_assertions (
    input logic                           clk10m,
    input logic                           rst_sync_n,
    input logic                           sysrst_nr0, clk10m_locked,
    input adc_data_pkg::lane_word_t       a_lane_a, a_lane_b, a_lane_c, a_lane_d,
    input adc_data_pkg::lane_word_t       b_lane_a, b_lane_b, b_lane_c, b_lane_d,
    input adc_data_pkg::lane_or_t         a_lane_or, b_lane_or, a_data_or, b_data_or,
    input adc_ctrl_pkg::interleave_mode_t a_mode, b_mode,
    input logic                           a_frame_valid, b_frame_valid,
    input logic                           a_adc_ready, b_adc_ready, sync_flag,
    input adc_data_pkg::sample_block_t    a_samples, b_samples,
    input logic                           a_samples_valid, b_samples_valid,
    input logic                           capture_ready, trig_ext
);
    import adc_ctrl_pkg::*;
    import adc_data_pkg::*;

    // failed checks so far, watched by the testbench top
    int unsigned fail_count = 0;

    // board reset released and clock locked
    logic board_up;

    // one-channel group order is A C B D
    localparam int ONE_CH_LANE [4] = '{0, 2, 1, 3};

    assign board_up = sysrst_nr0 && clk10m_locked;

    function automatic sample_t pick(lane_word_t w, int idx);
        return w[idx*`SAMPLE_W +: `SAMPLE_W];
    endfunction

    // expected output block, slot = group*4 + position
    function automatic sample_block_t expect_block(interleave_mode_t mode, lane_word_t la,
                                                   lane_word_t lb, lane_word_t lc,
                                                   lane_word_t ld);
        lane_word_t    w [4];
        sample_block_t blk;
        w[0] = la;
        w[1] = lb;
        w[2] = lc;
        w[3] = ld;
        blk = '0;
        for (int g = 0; g < 4; g++) begin
            for (int p = 0; p < 4; p++) begin
                case (mode)
                    MODE_1CH: blk[(g*4+p)*`SAMPLE_W +: `SAMPLE_W] = pick(w[ONE_CH_LANE[p]], g);
                    // A/B pair for groups 0,1 and C/D pair for groups 2,3
                    MODE_2CH: blk[(g*4+p)*`SAMPLE_W +: `SAMPLE_W] =
                        pick(w[(g/2)*2 + p%2], (g%2)*2 + p/2);
                    default: blk[(g*4+p)*`SAMPLE_W +: `SAMPLE_W] = pick(w[g], p);
                endcase
            end
        end
        return blk;
    endfunction

    // ----------------------------------------
    // reset and readiness
    // ----------------------------------------
    // async assert, release on the 2nd edge with both up
    rst_release: assert property (@(posedge clk10m)
        rst_sync_n == (board_up && $past(board_up) && $past(board_up, 2)))
    else begin
        fail_count++;
        $error("FAILED %0t: internal reset does not follow board reset and lock", $time);
    end

    reset_quiet: assert property (@(posedge clk10m)
        !rst_sync_n |-> !(capture_ready || a_samples_valid || b_samples_valid || trig_ext))
    else begin
        fail_count++;
        $error("FAILED %0t: output active while internal reset is held", $time);
    end

    ready_track: assert property (@(posedge clk10m) disable iff (!rst_sync_n)
        $past(rst_sync_n) |-> capture_ready == $past(a_adc_ready && b_adc_ready))
    else begin
        fail_count++;
        $error("FAILED %0t: capture_ready does not follow both ready inputs", $time);
    end

    // ----------------------------------------
    // accepted frames, two cycles of latency
    // ----------------------------------------
    a_valid_chk: assert property (@(posedge clk10m) disable iff (!rst_sync_n)
        a_samples_valid == $past(a_frame_valid && capture_ready, 2))
    else begin
        fail_count++;
        $error("FAILED %0t: a_samples_valid wrong for offered frame", $time);
    end

    b_valid_chk: assert property (@(posedge clk10m) disable iff (!rst_sync_n)
        b_samples_valid == $past(b_frame_valid && capture_ready, 2))
    else begin
        fail_count++;
        $error("FAILED %0t: b_samples_valid wrong for offered frame", $time);
    end

    a_data_chk: assert property (@(posedge clk10m) disable iff (!rst_sync_n)
        a_samples_valid |-> (a_data_or == $past(a_lane_or, 2)) &&
        (a_samples == expect_block($past(a_mode), $past(a_lane_a, 2), $past(a_lane_b, 2),
                                   $past(a_lane_c, 2), $past(a_lane_d, 2))))
    else begin
        fail_count++;
        $error("FAILED %0t: a_samples or a_data_or mismatch", $time);
    end

    b_data_chk: assert property (@(posedge clk10m) disable iff (!rst_sync_n)
        b_samples_valid |-> (b_data_or == $past(b_lane_or, 2)) &&
        (b_samples == expect_block($past(b_mode), $past(b_lane_a, 2), $past(b_lane_b, 2),
                                   $past(b_lane_c, 2), $past(b_lane_d, 2))))
    else begin
        fail_count++;
        $error("FAILED %0t: b_samples or b_data_or mismatch", $time);
    end

    // sync rise first seen at edge N gives trigger after edge N+2
    trig_chk: assert property (@(posedge clk10m) disable iff (!rst_sync_n)
        trig_ext == ($past(sync_flag, 3) && !$past(sync_flag, 4)))
    else begin
        fail_count++;
        $error("FAILED %0t: trig_ext pulse wrong for sync_flag edge", $time);
    end

endmodule

// ==== tb/tb_adc_capture.sv ====
// ----------------------------------------
// capture back end testbench
// reset, frame streams in all modes,
// ready drops, sync trigger and lock loss
// ----------------------------------------
`timescale 1ns/1ps

module tb_adc_capture;
    import adc_ctrl_pkg::*;
    import adc_data_pkg::*;

    // phase lengths in clk10m cycles
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = 24;
    localparam int SYNC_CYCLES  = 30;
    localparam int LOCK_CYCLES  = 3;
    localparam int DRAIN_CYCLES = 6;
    localparam int TEST_CYCLES  = RESET_CYCLES + 8 + 3*FRAME_CYCLES + 32 + SYNC_CYCLES
                                  + LOCK_CYCLES + DRAIN_CYCLES;
    localparam int MARGIN       = 50;

    logic             clk10m;
    logic             sysrst_nr0;
    logic             clk10m_locked;
    lane_word_t       a_lane_a, a_lane_b, a_lane_c, a_lane_d;
    lane_word_t       b_lane_a, b_lane_b, b_lane_c, b_lane_d;
    lane_or_t         a_lane_or, b_lane_or, a_data_or, b_data_or;
    logic             a_frame_valid, b_frame_valid;
    interleave_mode_t a_mode, b_mode;
    logic             a_adc_ready, b_adc_ready, sync_flag;
    sample_block_t    a_samples, b_samples;
    logic             a_samples_valid, b_samples_valid;
    logic             capture_ready, trig_ext;

    clk_gen u_clk_gen (.clk10m(clk10m));

    adc_capture_top UUT (.*);

    // property checks live inside the DUT top
    bind adc_capture_top adc_capture_assertions u_assert (.*);

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk10m);
        #10;
    endtask

    function automatic lane_word_t rand_word();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[39:0];
    endfunction

    // random frames on both paths, about 3 in 4 cycles valid
    task automatic offer_frames(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            a_lane_a      = rand_word();
            a_lane_b      = rand_word();
            a_lane_c      = rand_word();
            a_lane_d      = rand_word();
            b_lane_a      = rand_word();
            b_lane_b      = rand_word();
            b_lane_c      = rand_word();
            b_lane_d      = rand_word();
            a_lane_or     = 4'($urandom);
            b_lane_or     = 4'($urandom);
            a_frame_valid = ($urandom % 4) != 0;
            b_frame_valid = ($urandom % 4) != 0;
            next_cycle();
        end
        a_frame_valid = 1'b0;
        b_frame_valid = 1'b0;
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        void'($urandom(32'hfc18ecca));
        sysrst_nr0    = 1'b0;
        clk10m_locked = 1'b0;
        {a_lane_a, a_lane_b, a_lane_c, a_lane_d} = '0;
        {b_lane_a, b_lane_b, b_lane_c, b_lane_d} = '0;
        a_lane_or     = '0;
        b_lane_or     = '0;
        a_frame_valid = 1'b0;
        b_frame_valid = 1'b0;
        a_mode        = MODE_4CH;
        b_mode        = MODE_4CH;
        a_adc_ready   = 1'b0;
        b_adc_ready   = 1'b0;
        sync_flag     = 1'b0;

        // lock comes up while board reset is still held
        repeat (3) next_cycle();
        clk10m_locked = 1'b1;
        repeat (RESET_CYCLES - 3) next_cycle();
        sysrst_nr0 = 1'b1;

        // converters not ready, frames must be dropped
        offer_frames(8);

        a_adc_ready = 1'b1;
        b_adc_ready = 1'b1;
        // b on an undefined code, acts as 4-channel
        b_mode = interleave_mode_t'(4'b1100);
        offer_frames(FRAME_CYCLES);

        a_mode = MODE_2CH;
        b_mode = MODE_1CH;
        offer_frames(FRAME_CYCLES);
        a_mode = MODE_1CH;
        b_mode = MODE_2CH;
        offer_frames(FRAME_CYCLES);

        // ready drops on each converter in turn
        a_adc_ready = 1'b0;
        offer_frames(8);
        a_adc_ready = 1'b1;
        offer_frames(8);
        b_adc_ready = 1'b0;
        offer_frames(8);
        b_adc_ready = 1'b1;
        offer_frames(8);

        // held sync, then a one-cycle sync
        sync_flag = 1'b1;
        repeat (12) next_cycle();
        sync_flag = 1'b0;
        repeat (6) next_cycle();
        sync_flag = 1'b1;
        next_cycle();
        sync_flag = 1'b0;
        repeat (11) next_cycle();

        // lock lost for a moment, internal reset drops and recovers
        clk10m_locked = 1'b0;
        repeat (LOCK_CYCLES) next_cycle();
        clk10m_locked = 1'b1;

        repeat (DRAIN_CYCLES) next_cycle();
        if (UUT.u_assert.fail_count != 0) begin
            $display("Finished with errors");
            $fatal(1, "%0d assertion failures", UUT.u_assert.fail_count);
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // stop at the first failed property
    always @(posedge clk10m) begin
        if (UUT.u_assert.fail_count != 0) begin
            $display("Finished with errors");
            $fatal(1, "assertion failed, run stopped");
        end
    end

    // watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * 100);
        $display("Finished with errors");
        $fatal(1, "timeout, stimulus did not complete in time");
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/adc_data_pkg.sv
rtl/adc_ctrl_pkg.sv
rtl/adc_frame_if.sv
rtl/capture_sync.sv
rtl/lane_capture.sv
rtl/sample_reorder.sv
rtl/adc_capture_top.sv
tb/clk_gen.sv
tb/adc_capture_assertions.sv
tb/tb_adc_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the capture testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_adc_capture -o tb_adc_capture
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

# keep running past an assertion so the testbench reports and stops itself
./obj_dir/tb_adc_capture +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
